// ==== filelist.f ====
verilog/cpuPkg.sv
verilog/ControlUnit.sv
verilog/BranchControl.sv
verilog/RegisterFile.sv
verilog/Decode.sv
verilog/IdExRegister.sv
verilog/DecodeTop.sv
sim/tbDecodeTop.sv

// ==== sim/tbDecodeTop.sv ====
`timescale 1ns/100ps

module tbDecodeTop import cpuPkg::*; ();

  // DUT inputs
  logic    clk, rstN;
  flags_t  flags;
  logic    predictedTaken;
  word_t   instr, pcNext;
  regId_t  wbRegId;
  logic    wbRegWrite;
  word_t   wbData;
  logic    stall, flush;
  // DUT outputs
  logic    isBranch, taken, misprediction;
  word_t   branchTarget;
  regId_t  exSrcReg1, exSrcReg2, exRegId;
  word_t   exAluIn1, exAluIn2, exMemWriteData, exPcNext;
  opcode_t exAluOp;
  logic    exZEn, exNvEn, exMemEnable, exMemWrite, exRegWrite, exMemToReg, exHlt, exPcs;

  int          errorCount, timeoutCount, checkCount;
  word_t       regModel [NUM_REGS];  // Shadow of the register file
  logic [31:0] lfsr;

  DecodeTop DecodeTop_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random bits and compare tasks
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic nextBit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // Taps 32, 22, 2, 1
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic word_t randBits(input int n);  // n fresh bits, zero above
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[14:0], nextBit()};
    return v;
  endfunction

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkRegId(input string name, input regId_t got, input regId_t exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkOpcode(input string name, input opcode_t got, input opcode_t exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of the decode rules
  ////////////////////////////////////////////////////////////////////////////
  // {regWrite, memEnable, memWrite, memToReg, zEn, nvEn, hlt, pcs}
  function automatic logic [7:0] ctrlModel(input opcode_t op);
    logic [7:0] c;
    c[7] = (op <= OP_LW) || (op == OP_LLB) || (op == OP_LHB) || (op == OP_PCS);
    c[6] = (op == OP_LW) || (op == OP_SW);
    c[5] = (op == OP_SW);
    c[4] = (op == OP_LW);
    c[3] = (op <= OP_ROR);
    c[2] = (op == OP_ADD) || (op == OP_SUB);
    c[1] = (op == OP_HLT);
    c[0] = (op == OP_PCS);
    return c;
  endfunction

  function automatic regId_t src1Model(input word_t i);
    return (i[15:12] == OP_LLB || i[15:12] == OP_LHB) ? i[11:8] : i[7:4];
  endfunction

  function automatic regId_t src2Model(input word_t i);
    return (i[15:12] == OP_SW) ? i[11:8] : i[3:0];
  endfunction

  function automatic word_t aluIn2Model(input word_t i);
    word_t r;
    case (i[15:12])
      OP_LW, OP_SW:           r = {{12{i[3]}}, i[3:0]};  // Signed offset
      OP_SLL, OP_SRA, OP_ROR: r = {12'h000, i[3:0]};
      OP_LLB, OP_LHB:         r = {8'h00, i[7:0]};
      default:                r = regModel[src2Model(i)];
    endcase
    return r;
  endfunction

  function automatic logic condModel(input condCode_t cc, input flags_t f);
    logic z, v, n;
    {z, v, n} = f;
    case (cc)
      CC_NE:   return !z;
      CC_EQ:   return z;
      CC_GT:   return !z && !n;
      CC_LT:   return n;
      CC_GE:   return z || !n;
      CC_LE:   return n || z;
      CC_OV:   return v;
      default: return 1'b1;  // CC_UN
    endcase
  endfunction

  function automatic word_t targetModel(input word_t i, input word_t pc);
    if (i[15:12] == OP_BR) return regModel[src1Model(i)];
    return pc + {{6{i[8]}}, i[8:0], 1'b0};  // Half-word offset
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic checkEx(input word_t i, input word_t pc);
    logic [7:0] c;
    c = ctrlModel(i[15:12]);
    checkRegId("exSrcReg1", exSrcReg1, src1Model(i));
    checkRegId("exSrcReg2", exSrcReg2, src2Model(i));
    checkRegId("exRegId", exRegId, i[11:8]);
    checkOpcode("exAluOp", exAluOp, i[15:12]);
    checkWord("exAluIn1", exAluIn1, regModel[src1Model(i)]);
    checkWord("exAluIn2", exAluIn2, aluIn2Model(i));
    checkWord("exMemWriteData", exMemWriteData, regModel[src2Model(i)]);
    checkBit("exRegWrite", exRegWrite, c[7]);
    checkBit("exMemEnable", exMemEnable, c[6]);
    checkBit("exMemWrite", exMemWrite, c[5]);
    checkBit("exMemToReg", exMemToReg, c[4]);
    checkBit("exZEn", exZEn, c[3]);
    checkBit("exNvEn", exNvEn, c[2]);
    checkBit("exHlt", exHlt, c[1]);
    checkBit("exPcs", exPcs, c[0]);
    checkWord("exPcNext", exPcNext, pc);
  endtask

  // Bubble, every enable low
  task automatic checkBubble();
    checkBit("exRegWrite", exRegWrite, 1'b0);
    checkBit("exMemEnable", exMemEnable, 1'b0);
    checkBit("exMemWrite", exMemWrite, 1'b0);
    checkBit("exMemToReg", exMemToReg, 1'b0);
    checkBit("exZEn", exZEn, 1'b0);
    checkBit("exNvEn", exNvEn, 1'b0);
    checkBit("exHlt", exHlt, 1'b0);
    checkBit("exPcs", exPcs, 1'b0);
  endtask

  // One instruction through ID/EX, optional write-back in the same cycle
  task automatic issue(input word_t i, input word_t pc, input logic wbEn,
                       input regId_t wbId, input word_t wbVal);
    @(negedge clk);
    instr      = i;
    pcNext     = pc;
    wbRegWrite = wbEn;
    wbRegId    = wbId;
    wbData     = wbVal;
    if (wbEn && wbId != '0) regModel[wbId] = wbVal;  // Bypass shows it at once
    @(negedge clk);
    wbRegWrite = 1'b0;
    checkEx(i, pc);
  endtask

  task automatic branchCase(input word_t i, input word_t pc, input flags_t f,
                            input logic pred);
    logic isBr, expTaken;
    @(negedge clk);
    instr          = i;
    pcNext         = pc;
    flags          = f;
    predictedTaken = pred;
    #1;                                     // Settle the combinational path
    isBr     = (i[15:12] == OP_B) || (i[15:12] == OP_BR);
    expTaken = isBr && condModel(i[11:9], f);
    checkBit("isBranch", isBranch, isBr);
    checkBit("taken", taken, expTaken);
    checkBit("misprediction", misprediction, expTaken != pred);
    if (isBr) checkWord("branchTarget", branchTarget, targetModel(i, pc));
  endtask

  task automatic waitForBubble(input int maxCycles);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < maxCycles && !seen; n++) begin
      @(negedge clk);
      seen = !exRegWrite && !exMemEnable && !exMemWrite && !exHlt && !exPcs;
    end
    if (!seen) begin
      timeoutCount++;
      $display("Timeout: ID/EX did not load a bubble within %0d cycles of flush",
               maxCycles);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic testReset();
    checkBubble();                                  // Straight out of reset
    checkRegId("exSrcReg1", exSrcReg1, '0);
    checkRegId("exSrcReg2", exSrcReg2, '0);
    checkRegId("exRegId", exRegId, '0);
    checkOpcode("exAluOp", exAluOp, '0);
    checkWord("exAluIn1", exAluIn1, '0);
    checkWord("exAluIn2", exAluIn2, '0);
    checkWord("exMemWriteData", exMemWriteData, '0);
    checkWord("exPcNext", exPcNext, '0);
    for (int r = 0; r < NUM_REGS; r++) begin
      issue({OP_ADD, 4'h1, regId_t'(r), regId_t'(r)}, 16'h0010, 1'b0, '0, '0);
    end
  endtask

  task automatic testRegFile();
    for (int r = 1; r < NUM_REGS; r++) begin        // Store data sees the bypass
      issue({OP_SW, regId_t'(r), 8'h00}, 16'h0100, 1'b1, regId_t'(r), randBits(16));
    end
    issue({OP_ADD, 4'h1, 4'h0, 4'h0}, 16'h0200, 1'b1, 4'h0, 16'hbeef);  // R0 ignores it
    issue({OP_ADD, 4'h1, 4'h0, 4'h0}, 16'h0202, 1'b0, '0, '0);
    for (int r = 1; r < NUM_REGS; r++) begin        // Read back after the writes
      issue({OP_ADD, 4'h2, regId_t'(r), regId_t'(r - 1)}, 16'h0300, 1'b0, '0, '0);
    end
    issue({OP_ADD, 4'h3, 4'h7, 4'h7}, 16'h0400, 1'b1, 4'h7, 16'h1234);  // Both ports
  endtask

  task automatic testAluDecode();
    for (int o = 0; o <= OP_LHB; o++) begin         // R-types, shifts, LW, SW, LLB, LHB
      for (int k = 0; k < 3; k++) begin
        issue({opcode_t'(o), 12'h000} | randBits(12), randBits(16), 1'b0, '0, '0);
      end
    end
    issue({OP_LW, 4'h1, 4'h2, 4'hc}, 16'h0500, 1'b0, '0, '0);   // Negative offset
    issue({OP_SW, 4'h3, 4'h4, 4'h9}, 16'h0502, 1'b0, '0, '0);
    issue({OP_SLL, 4'h5, 4'h6, 4'hf}, 16'h0504, 1'b0, '0, '0);  // No sign extension
    issue({OP_LLB, 4'h8, 8'hf0}, 16'h0506, 1'b0, '0, '0);
    issue({OP_LHB, 4'h9, 8'h81}, 16'h0508, 1'b0, '0, '0);
  endtask

  task automatic testBranches();
    opcode_t op;
    for (int b = 0; b < 2; b++) begin
      op = b ? OP_BR : OP_B;
      for (int c = 0; c < 8; c++) begin
        for (int p = 0; p < 4; p++) begin            // Two flag draws, each guess
          branchCase({op, condCode_t'(c), 9'h000} | randBits(9), randBits(16),
                     flags_t'(randBits(3)), p[0]);
        end
      end
    end
    for (int o = 0; o < 16; o++) begin              // Non-branches never redirect
      if (o == OP_B || o == OP_BR) continue;
      branchCase({opcode_t'(o), 12'h000} | randBits(12), randBits(16),
                 flags_t'(randBits(3)), randBits(1) != 0);
    end
  endtask

  task automatic testControl();
    for (int k = 0; k < 2; k++) begin
      issue({OP_LW, 12'h000} | randBits(12), randBits(16), 1'b0, '0, '0);
      issue({OP_SW, 12'h000} | randBits(12), randBits(16), 1'b0, '0, '0);
      issue({OP_PCS, 12'h000} | randBits(12), randBits(16), 1'b0, '0, '0);
      issue({OP_HLT, 12'h000} | randBits(12), randBits(16), 1'b0, '0, '0);
    end
  endtask

  task automatic testStallFlush();
    word_t held, heldPc;
    held   = {OP_LW, 4'h3, 4'h5, 4'he};
    heldPc = 16'h0420;
    issue(held, heldPc, 1'b0, '0, '0);
    @(negedge clk);
    stall  = 1'b1;
    instr  = {OP_HLT, 12'h000};                     // Must not get through
    pcNext = 16'hfffe;
    for (int n = 0; n < 4; n++) begin
      @(negedge clk);
      checkEx(held, heldPc);
    end
    flush = 1'b1;                                   // Stall still high
    waitForBubble(3);
    flush = 1'b0;
    checkBubble();
    @(negedge clk);
    checkBubble();                                  // Stall keeps the bubble
    stall = 1'b0;
    issue({OP_SUB, 4'h2, 4'h7, 4'h3}, 16'h0430, 1'b0, '0, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    lfsr           = 32'h5d70;
    errorCount     = 0;
    timeoutCount   = 0;
    checkCount     = 0;
    rstN           = 1'b0;
    flags          = '0;
    predictedTaken = 1'b0;
    instr          = '0;
    pcNext         = '0;
    wbRegId        = '0;
    wbRegWrite     = 1'b0;
    wbData         = '0;
    stall          = 1'b0;
    flush          = 1'b0;
    for (int r = 0; r < NUM_REGS; r++) regModel[r] = '0;

    for (int n = 0; n < 16; n++) @(posedge clk);   // 16 reset cycles
    @(negedge clk);
    rstN = 1'b1;

    testReset();
    testRegFile();
    testAluDecode();
    testBranches();
    testControl();
    testStallFlush();

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
             checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verilog/BranchControl.sv ====
`timescale 1ns/100ps

module BranchControl import cpuPkg::*; (
  input  condCode_t  condCode,     // Instruction bits 11..9
  input  branchImm_t branchImm,    // Instruction bits 8..0
  input  flags_t     flags,        // Current Z, V, N
  input  word_t      rsData,       // Register target for BR
  input  logic       isRegBranch,  // BR rather than B
  input  logic       branch,       // Opcode is a branch
  input  word_t      pcNext,       // PC of the following instruction
  output logic       taken,
  output word_t      target
);

  logic  condMet;     // Condition holds for the current flags
  word_t offset;      // Sign-extended byte offset
  logic  fz, fv, fn;

  assign fz = flags[FLAG_Z];
  assign fv = flags[FLAG_V];
  assign fn = flags[FLAG_N];

  always_comb begin
    case (condCode)
      CC_NE:   condMet = !fz;
      CC_EQ:   condMet = fz;
      CC_GT:   condMet = !fz && !fn;
      CC_LT:   condMet = fn;
      CC_GE:   condMet = fz || !fn;
      CC_LE:   condMet = fn || fz;
      CC_OV:   condMet = fv;
      CC_UN:   condMet = 1'b1;
      default: condMet = 1'b0;
    endcase
  end

  assign taken = branch && condMet;  // Only branches can redirect

  // Half-word offset, sign-extended then doubled
  assign offset = {{6{branchImm[8]}}, branchImm, 1'b0};
  assign target = isRegBranch ? rsData : pcNext + offset;

endmodule

// ==== verilog/ControlUnit.sv ====
`timescale 1ns/100ps

module ControlUnit import cpuPkg::*; (
  input  opcode_t opcode,     // Instruction bits 15..12
  output logic    aluSrc,     // ALU operand 2 from the immediate
  output logic    memToReg,   // Write back the load data
  output logic    regWrite,   // Result goes to the register file
  output logic    regSrc,     // LLB/LHB, rd is also a source
  output logic    memEnable,  // Data memory access
  output logic    memWrite,   // Store
  output logic    branch,     // B or BR
  output logic    hlt,        // Halt
  output logic    pcs,        // Save PC
  output logic    zEn,        // Update Z
  output logic    nvEn        // Update N and V
);

  always_comb begin
    // Everything off unless the opcode says otherwise
    aluSrc    = 1'b0;
    memToReg  = 1'b0;
    regWrite  = 1'b0;
    regSrc    = 1'b0;
    memEnable = 1'b0;
    memWrite  = 1'b0;
    branch    = 1'b0;
    hlt       = 1'b0;
    pcs       = 1'b0;
    zEn       = 1'b0;
    nvEn      = 1'b0;

    case (opcode)
      OP_ADD, OP_SUB: begin  // Arithmetic sets all three flags
        regWrite = 1'b1;
        zEn      = 1'b1;
        nvEn     = 1'b1;
      end
      OP_XOR, OP_RED: begin
        regWrite = 1'b1;
        zEn      = 1'b1;
      end
      OP_SLL, OP_SRA, OP_ROR: begin  // Shift amount is the 4-bit immediate
        regWrite = 1'b1;
        zEn      = 1'b1;
        aluSrc   = 1'b1;
      end
      OP_PADDSB: regWrite = 1'b1;  // No flag update
      OP_LW: begin
        regWrite  = 1'b1;
        memEnable = 1'b1;
        memToReg  = 1'b1;
        aluSrc    = 1'b1;          // Base plus offset
      end
      OP_SW: begin
        memEnable = 1'b1;
        memWrite  = 1'b1;
        aluSrc    = 1'b1;
      end
      OP_LLB, OP_LHB: begin
        regWrite = 1'b1;
        regSrc   = 1'b1;
        aluSrc   = 1'b1;           // 8-bit immediate
      end
      OP_B, OP_BR: branch = 1'b1;
      OP_PCS: begin
        regWrite = 1'b1;
        pcs      = 1'b1;
      end
      OP_HLT: hlt = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== verilog/Decode.sv ====
`timescale 1ns/100ps

module Decode import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  flags_t  flags,           // Z, V, N from execute
  input  logic    predictedTaken,  // Fetch's guess
  input  word_t   instr,
  input  word_t   pcNext,
  input  regId_t  wbRegId,         // Write-back port
  input  logic    wbRegWrite,
  input  word_t   wbData,
  output regId_t  srcReg1,
  output regId_t  srcReg2,
  output regId_t  regId,           // Destination rd
  output word_t   aluIn1,
  output word_t   aluIn2,
  output word_t   memWriteData,
  output opcode_t aluOp,
  output logic    zEn,
  output logic    nvEn,
  output logic    memEnable,
  output logic    memWrite,
  output logic    regWrite,
  output logic    memToReg,
  output logic    hlt,
  output logic    pcs,
  output logic    isBranch,
  output logic    taken,
  output logic    misprediction,
  output word_t   branchTarget
);

  ////////////////////////////////////////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////////////////////////////////////////
  opcode_t opcode;
  regId_t  rd, rs, rt;
  logic    aluSrc;             // Operand 2 from the immediate
  logic    regSrc;             // LLB/LHB
  word_t   srcData1, srcData2;
  word_t   imm;                // Extended immediate

  assign opcode = instr[15:12];
  assign rd     = instr[11:8];
  assign rs     = instr[7:4];
  assign rt     = instr[3:0];
  assign regId  = rd;
  assign aluOp  = opcode;      // ALU decodes the opcode directly

  ControlUnit ControlUnit_inst (
    .opcode    (opcode),
    .aluSrc    (aluSrc),
    .memToReg  (memToReg),
    .regWrite  (regWrite),
    .regSrc    (regSrc),
    .memEnable (memEnable),
    .memWrite  (memWrite),
    .branch    (isBranch),
    .hlt       (hlt),
    .pcs       (pcs),
    .zEn       (zEn),
    .nvEn      (nvEn)
  );

  // LLB/LHB read rd to merge the other byte, SW reads rd as store data
  assign srcReg1 = regSrc   ? rd : rs;
  assign srcReg2 = memWrite ? rd : rt;

  RegisterFile RegisterFile_inst (
    .clk      (clk),
    .rstN     (rstN),
    .srcReg1  (srcReg1),
    .srcReg2  (srcReg2),
    .dstReg   (wbRegId),
    .writeReg (wbRegWrite),
    .dstData  (wbData),
    .srcData1 (srcData1),
    .srcData2 (srcData2)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    if (regSrc)         imm = {8'h00, instr[7:0]};               // LLB/LHB byte
    else if (memEnable) imm = {{12{instr[3]}}, instr[3:0]};      // Signed offset
    else                imm = {12'h000, instr[3:0]};             // Shift amount
  end

  assign aluIn1       = srcData1;
  assign aluIn2       = aluSrc ? imm : srcData2;
  assign memWriteData = srcData2;

  BranchControl BranchControl_inst (
    .condCode    (instr[11:9]),
    .branchImm   (instr[8:0]),
    .flags       (flags),
    .rsData      (srcData1),
    .isRegBranch (opcode == OP_BR),
    .branch      (isBranch),
    .pcNext      (pcNext),
    .taken       (taken),
    .target      (branchTarget)
  );

  assign misprediction = taken != predictedTaken;  // Fetch guessed wrong

endmodule

// ==== verilog/DecodeTop.sv ====
`timescale 1ns/100ps

module DecodeTop import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  flags_t  flags,
  input  logic    predictedTaken,
  input  word_t   instr,
  input  word_t   pcNext,
  input  regId_t  wbRegId,
  input  logic    wbRegWrite,
  input  word_t   wbData,
  input  logic    stall,
  input  logic    flush,
  output logic    isBranch,        // Branch outputs bypass ID/EX
  output logic    taken,
  output logic    misprediction,
  output word_t   branchTarget,
  output regId_t  exSrcReg1,
  output regId_t  exSrcReg2,
  output regId_t  exRegId,
  output word_t   exAluIn1,
  output word_t   exAluIn2,
  output word_t   exMemWriteData,
  output opcode_t exAluOp,
  output logic    exZEn,
  output logic    exNvEn,
  output logic    exMemEnable,
  output logic    exMemWrite,
  output logic    exRegWrite,
  output logic    exMemToReg,
  output logic    exHlt,
  output logic    exPcs,
  output word_t   exPcNext
);

  // Decode to ID/EX
  regId_t  srcReg1, srcReg2, regId;
  word_t   aluIn1, aluIn2, memWriteData;
  opcode_t aluOp;
  logic    zEn, nvEn, memEnable, memWrite, regWrite, memToReg, hlt, pcs;

  Decode Decode_inst (
    .clk            (clk),
    .rstN           (rstN),
    .flags          (flags),
    .predictedTaken (predictedTaken),
    .instr          (instr),
    .pcNext         (pcNext),
    .wbRegId        (wbRegId),
    .wbRegWrite     (wbRegWrite),
    .wbData         (wbData),
    .srcReg1        (srcReg1),
    .srcReg2        (srcReg2),
    .regId          (regId),
    .aluIn1         (aluIn1),
    .aluIn2         (aluIn2),
    .memWriteData   (memWriteData),
    .aluOp          (aluOp),
    .zEn            (zEn),
    .nvEn           (nvEn),
    .memEnable      (memEnable),
    .memWrite       (memWrite),
    .regWrite       (regWrite),
    .memToReg       (memToReg),
    .hlt            (hlt),
    .pcs            (pcs),
    .isBranch       (isBranch),
    .taken          (taken),
    .misprediction  (misprediction),
    .branchTarget   (branchTarget)
  );

  IdExRegister IdExRegister_inst (
    .clk            (clk),
    .rstN           (rstN),
    .stall          (stall),
    .flush          (flush),
    .srcReg1        (srcReg1),
    .srcReg2        (srcReg2),
    .regId          (regId),
    .aluIn1         (aluIn1),
    .aluIn2         (aluIn2),
    .memWriteData   (memWriteData),
    .aluOp          (aluOp),
    .zEn            (zEn),
    .nvEn           (nvEn),
    .memEnable      (memEnable),
    .memWrite       (memWrite),
    .regWrite       (regWrite),
    .memToReg       (memToReg),
    .hlt            (hlt),
    .pcs            (pcs),
    .pcNext         (pcNext),      // PC travels along for PCS
    .exSrcReg1      (exSrcReg1),
    .exSrcReg2      (exSrcReg2),
    .exRegId        (exRegId),
    .exAluIn1       (exAluIn1),
    .exAluIn2       (exAluIn2),
    .exMemWriteData (exMemWriteData),
    .exAluOp        (exAluOp),
    .exZEn          (exZEn),
    .exNvEn         (exNvEn),
    .exMemEnable    (exMemEnable),
    .exMemWrite     (exMemWrite),
    .exRegWrite     (exRegWrite),
    .exMemToReg     (exMemToReg),
    .exHlt          (exHlt),
    .exPcs          (exPcs),
    .exPcNext       (exPcNext)
  );

endmodule

// ==== verilog/IdExRegister.sv ====
`timescale 1ns/100ps

module IdExRegister import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    stall,           // Hold
  input  logic    flush,           // Bubble, wins over stall
  input  regId_t  srcReg1,
  input  regId_t  srcReg2,
  input  regId_t  regId,
  input  word_t   aluIn1,
  input  word_t   aluIn2,
  input  word_t   memWriteData,
  input  opcode_t aluOp,
  input  logic    zEn,
  input  logic    nvEn,
  input  logic    memEnable,
  input  logic    memWrite,
  input  logic    regWrite,
  input  logic    memToReg,
  input  logic    hlt,
  input  logic    pcs,
  input  word_t   pcNext,
  output regId_t  exSrcReg1,
  output regId_t  exSrcReg2,
  output regId_t  exRegId,
  output word_t   exAluIn1,
  output word_t   exAluIn2,
  output word_t   exMemWriteData,
  output opcode_t exAluOp,
  output logic    exZEn,
  output logic    exNvEn,
  output logic    exMemEnable,
  output logic    exMemWrite,
  output logic    exRegWrite,
  output logic    exMemToReg,
  output logic    exHlt,
  output logic    exPcs,
  output word_t   exPcNext
);

  always_ff @(posedge clk) begin
    if (!rstN || flush) begin  // Reset and bubble look the same downstream
      exSrcReg1      <= '0;
      exSrcReg2      <= '0;
      exRegId        <= '0;
      exAluIn1       <= '0;
      exAluIn2       <= '0;
      exMemWriteData <= '0;
      exAluOp        <= '0;
      exZEn          <= 1'b0;
      exNvEn         <= 1'b0;
      exMemEnable    <= 1'b0;
      exMemWrite     <= 1'b0;
      exRegWrite     <= 1'b0;
      exMemToReg     <= 1'b0;
      exHlt          <= 1'b0;
      exPcs          <= 1'b0;
      exPcNext       <= '0;
    end else if (!stall) begin
      exSrcReg1      <= srcReg1;
      exSrcReg2      <= srcReg2;
      exRegId        <= regId;
      exAluIn1       <= aluIn1;
      exAluIn2       <= aluIn2;
      exMemWriteData <= memWriteData;
      exAluOp        <= aluOp;
      exZEn          <= zEn;
      exNvEn         <= nvEn;
      exMemEnable    <= memEnable;
      exMemWrite     <= memWrite;
      exRegWrite     <= regWrite;
      exMemToReg     <= memToReg;
      exHlt          <= hlt;
      exPcs          <= pcs;
      exPcNext       <= pcNext;
    end
  end

  // A flushed slot must not write state or halt, even with stall high
  bubbleIsInert: assert property (@(posedge clk) disable iff (!rstN)
    flush |=> !exRegWrite && !exMemWrite && !exHlt)
    else $error("Flushed ID/EX slot still carries side effects");

endmodule

// ==== verilog/RegisterFile.sv ====
`timescale 1ns/100ps

module RegisterFile import cpuPkg::*; (
  input  logic   clk,
  input  logic   rstN,      // Synchronous, active low
  input  regId_t srcReg1,   // Read port 1 address
  input  regId_t srcReg2,   // Read port 2 address
  input  regId_t dstReg,    // Write port address
  input  logic   writeReg,  // Write strobe
  input  word_t  dstData,   // Write data
  output word_t  srcData1,
  output word_t  srcData2
);

  word_t regs [NUM_REGS];
  logic  wrValid;  // Write that actually lands

  assign wrValid = writeReg && (dstReg != '0);  // R0 stays zero

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrValid) begin
      regs[dstReg] <= dstData;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports with write-before-read bypass
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    if (srcReg1 == '0)                     srcData1 = '0;
    else if (wrValid && dstReg == srcReg1) srcData1 = dstData;  // Bypass
    else                                   srcData1 = regs[srcReg1];
  end

  always_comb begin
    if (srcReg2 == '0)                     srcData2 = '0;
    else if (wrValid && dstReg == srcReg2) srcData2 = dstData;
    else                                   srcData2 = regs[srcReg2];
  end

  // R0 reads as zero on both ports, also while it is the write target
  r0ReadsZero1: assert property (@(posedge clk) disable iff (!rstN)
    (srcReg1 == '0) |-> (srcData1 == '0))
    else $error("R0 read nonzero on port 1");

  r0ReadsZero2: assert property (@(posedge clk) disable iff (!rstN)
    (srcReg2 == '0) |-> (srcData2 == '0))
    else $error("R0 read nonzero on port 2");

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [15:0] word_t;       // Data word and address
  typedef logic [3:0]  regId_t;      // Register number
  typedef logic [3:0]  opcode_t;     // Opcode, doubles as ALU operation
  typedef logic [2:0]  flags_t;      // {Z, V, N}
  typedef logic [2:0]  condCode_t;   // Branch condition
  typedef logic [8:0]  branchImm_t;  // Offset in half-words

  localparam int NUM_REGS = 16;

  // Bit positions inside flags_t
  localparam int FLAG_Z = 2;
  localparam int FLAG_V = 1;
  localparam int FLAG_N = 0;

  // Opcodes
  localparam opcode_t OP_ADD    = 4'h0;
  localparam opcode_t OP_SUB    = 4'h1;
  localparam opcode_t OP_XOR    = 4'h2;
  localparam opcode_t OP_RED    = 4'h3;
  localparam opcode_t OP_SLL    = 4'h4;
  localparam opcode_t OP_SRA    = 4'h5;
  localparam opcode_t OP_ROR    = 4'h6;
  localparam opcode_t OP_PADDSB = 4'h7;
  localparam opcode_t OP_LW     = 4'h8;
  localparam opcode_t OP_SW     = 4'h9;
  localparam opcode_t OP_LLB    = 4'hA;
  localparam opcode_t OP_LHB    = 4'hB;
  localparam opcode_t OP_B      = 4'hC;
  localparam opcode_t OP_BR     = 4'hD;
  localparam opcode_t OP_PCS    = 4'hE;
  localparam opcode_t OP_HLT    = 4'hF;

  // Branch condition codes
  localparam condCode_t CC_NE = 3'b000;  // Z=0
  localparam condCode_t CC_EQ = 3'b001;  // Z=1
  localparam condCode_t CC_GT = 3'b010;  // Z=0 and N=0
  localparam condCode_t CC_LT = 3'b011;  // N=1
  localparam condCode_t CC_GE = 3'b100;  // Z=1 or N=0
  localparam condCode_t CC_LE = 3'b101;  // N=1 or Z=1
  localparam condCode_t CC_OV = 3'b110;  // V=1
  localparam condCode_t CC_UN = 3'b111;  // Always

endpackage
